/* logic/decodePkg.sv */
package decodePkg;

  typedef logic [31:0] instrT;
  typedef logic [3:0]  aluCtrlT;  // RISC-V encodings, ARM codes zero-extended
  typedef logic [3:0]  condT;
  typedef logic [1:0]  memSizeT;  // byte, half, word
  typedef logic [2:0]  immSrcT;
  typedef logic [2:0]  creditT;

  localparam int OUT_DEPTH    = 2;  // stage buffer, power of two
  localparam int OUT_PTR_W    = $clog2(OUT_DEPTH);
  localparam int EXEC_CREDITS = 4;  // execute queue depth
  localparam int BUNDLE_W     = 28; // packed control bundle width

  localparam condT    COND_ALWAYS = 4'b1110;
  localparam memSizeT MEM_WORD    = 2'b10;

  // RV32I major opcodes
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_RTYPE  = 7'b0110011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_ITYPE  = 7'b0010011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;

  // ARM op field, instr[27:26]
  localparam logic [1:0] ARM_OP_DP  = 2'b00;
  localparam logic [1:0] ARM_OP_MEM = 2'b01;
  localparam logic [1:0] ARM_OP_BR  = 2'b10;

endpackage

/* logic/rvDecoder.sv */
`timescale 1ns/100ps

module rvDecoder (
  input  decodePkg::instrT   instr,
  output logic               rvValid,
  output logic               regWrite,
  output logic               memWrite,
  output decodePkg::memSizeT memSize,
  output logic               memSigned,
  output decodePkg::aluCtrlT aluControl,
  output logic [1:0]         branch,
  output logic               aluSrc,
  output decodePkg::immSrcT  immSrc,
  output decodePkg::condT    cond,
  output logic [1:0]         resultSrc,
  output logic               jump,
  output logic               pcRes
);

  logic [6:0]  op;
  logic [2:0]  funct3;
  logic        funct7b5;
  logic [1:0]  aluOp;
  logic [16:0] controls;
  logic        mainValid;
  logic        condValid;

  assign op       = instr[6:0];
  assign funct3   = instr[14:12];
  assign funct7b5 = instr[30];

  assign {regWrite, immSrc, aluSrc, memWrite, memSigned, memSize,
          resultSrc, branch, aluOp, jump, pcRes} = controls;

  assign rvValid = mainValid & condValid;

  // regWrite_immSrc_aluSrc_memWrite_memSigned_memSize_resultSrc_branch_aluOp_jump_pcRes
  always_comb begin
    mainValid = 1'b1;
    controls  = '0;
    case (op)
      decodePkg::OP_LOAD:
        case (funct3)
          3'b000:  controls = 17'b1_000_1_0_1_00_01_00_00_0_0; // lb
          3'b001:  controls = 17'b1_000_1_0_1_01_01_00_00_0_0; // lh
          3'b010:  controls = 17'b1_000_1_0_0_10_01_00_00_0_0; // lw
          3'b100:  controls = 17'b1_000_1_0_0_00_01_00_00_0_0; // lbu
          3'b101:  controls = 17'b1_000_1_0_0_01_01_00_00_0_0; // lhu
          default: mainValid = 1'b0;
        endcase
      decodePkg::OP_STORE:
        case (funct3)
          3'b000:  controls = 17'b0_001_1_1_0_00_00_00_00_0_0; // sb
          3'b001:  controls = 17'b0_001_1_1_0_01_00_00_00_0_0; // sh
          3'b010:  controls = 17'b0_001_1_1_0_10_00_00_00_0_0; // sw
          default: mainValid = 1'b0;
        endcase
      decodePkg::OP_RTYPE:  controls = 17'b1_000_0_0_0_00_00_00_10_0_0;
      decodePkg::OP_BRANCH: controls = 17'b0_010_0_0_0_00_00_01_01_0_0;
      decodePkg::OP_ITYPE:  controls = 17'b1_000_1_0_0_00_00_00_10_0_0;
      decodePkg::OP_JAL:    controls = 17'b1_011_0_0_0_00_10_01_00_1_0;
      decodePkg::OP_JALR:   controls = 17'b1_000_1_0_0_00_10_01_00_1_0;
      decodePkg::OP_LUI:    controls = 17'b1_111_1_0_0_00_00_00_11_0_0;
      decodePkg::OP_AUIPC:  controls = 17'b1_111_0_0_0_00_10_00_00_0_1; // pc-relative result
      default:              mainValid = 1'b0;
    endcase
  end

  always_comb begin
    case (aluOp)
      2'b00: aluControl = 4'b0000; // add for address calc
      2'b01: aluControl = 4'b0001; // sub for compare
      2'b11: aluControl = 4'b0110; // lui passthrough
      default:
        case (funct3)
          3'b000:         aluControl = (funct7b5 & op[5]) ? 4'b0001 : 4'b0000; // sub only in R-type
          3'b001:         aluControl = 4'b1000; // sll
          3'b101:         aluControl = funct7b5 ? 4'b1010 : 4'b1001; // sra or srl
          3'b010, 3'b011: aluControl = 4'b0101; // slt, sltu
          3'b100:         aluControl = 4'b0100; // xor
          3'b110:         aluControl = 4'b0011; // or
          default:        aluControl = 4'b0010; // and
        endcase
    endcase
  end

  // aluOp 01 only comes from B-type
  always_comb begin
    condValid = 1'b1;
    cond      = decodePkg::COND_ALWAYS;
    if (aluOp == 2'b01) begin
      case (funct3)
        3'b000:  cond = 4'b0000; // beq
        3'b001:  cond = 4'b0001; // bne
        3'b100:  cond = 4'b1011; // blt
        3'b101:  cond = 4'b1010; // bge
        3'b110:  cond = 4'b0010; // bltu
        3'b111:  cond = 4'b0011; // bgeu
        default: begin
          cond      = '0;
          condValid = 1'b0;
        end
      endcase
    end
  end

endmodule

/* logic/armDecoder.sv */
`timescale 1ns/100ps

module armDecoder (
  input  decodePkg::instrT instr,
  output logic             armValid,
  output logic             regWrite,
  output logic             memWrite,
  output logic             memtoReg,
  output logic             aluSrc,
  output logic [1:0]       immSrc,
  output logic [1:0]       regSrc,
  output logic [1:0]       aluControl,
  output logic             branch,
  output logic [1:0]       flagWrite,
  output logic             pcSrc
);

  logic [1:0] op;
  logic [5:0] funct;
  logic [3:0] rd;
  logic [9:0] controls;
  logic       aluOp;
  logic       mainValid;
  logic       aluValid;
  logic       arith;

  assign op    = instr[27:26];
  assign funct = instr[25:20];
  assign rd    = instr[15:12];

  assign {regSrc, immSrc, aluSrc, memtoReg, regWrite, memWrite, branch, aluOp} = controls;

  assign armValid = mainValid & aluValid;

  always_comb begin
    mainValid = 1'b1;
    case (op)
      decodePkg::ARM_OP_DP:  controls = funct[5] ? 10'b00_00_1_0_1_0_0_1   // immediate operand
                                                 : 10'b00_00_0_0_1_0_0_1;  // register operand
      decodePkg::ARM_OP_MEM: controls = funct[0] ? 10'b00_01_1_1_1_0_0_0   // ldr
                                                 : 10'b10_01_1_1_0_1_0_0;  // str
      decodePkg::ARM_OP_BR:  controls = 10'b01_10_1_0_0_0_1_0;
      default: begin
        controls  = '0;
        mainValid = 1'b0;
      end
    endcase
  end

  always_comb begin
    aluValid   = 1'b1;
    aluControl = 2'b00; // non-DP instructions add
    arith      = 1'b0;
    if (aluOp) begin
      case (funct[4:1])
        4'b0100: arith = 1'b1;  // ADD
        4'b0010: begin          // SUB
          aluControl = 2'b01;
          arith      = 1'b1;
        end
        4'b0000: aluControl = 2'b10; // AND
        4'b1100: aluControl = 2'b11; // ORR
        default: aluValid = 1'b0;
      endcase
    end
  end

  // S bit sets NZ, C and V only for arithmetic ops
  assign flagWrite = {aluOp & funct[0], funct[0] & arith};

  assign pcSrc = (rd == 4'b1111) & regWrite; // write to r15
endmodule

/* logic/combiDecoder.sv */
`timescale 1ns/100ps

module combiDecoder (
  input  decodePkg::instrT   instr,
  input  logic               flushed,
  input  logic               armIn,
  output logic               armNext,
  output logic               illegal,
  output logic               regWrite,
  output logic               memWrite,
  output decodePkg::memSizeT memSize,
  output logic               memSigned,
  output decodePkg::aluCtrlT aluControl,
  output logic [1:0]         branch,
  output logic               aluSrc,
  output decodePkg::immSrcT  immSrc,
  output decodePkg::condT    cond,
  output logic               pcSrc,
  output logic [1:0]         flagWrite,
  output logic [1:0]         regSrc,
  output logic [1:0]         resultSrc,
  output logic               jump,
  output logic               pcRes
);

  logic               rvValid, rvRegWrite, rvMemWrite, rvMemSigned, rvAluSrc, rvJump, rvPcRes;
  decodePkg::memSizeT rvMemSize;
  decodePkg::aluCtrlT rvAluControl;
  decodePkg::immSrcT  rvImmSrc;
  decodePkg::condT    rvCond;
  logic [1:0]         rvBranch, rvResultSrc;

  logic       armValid, armRegWrite, armMemWrite, armMemtoReg, armAluSrc, armBranch, armPcSrc;
  logic [1:0] armImmSrc, armRegSrc, armAluControl, armFlagWrite;

  rvDecoder u_rvDecoder (
    .instr      (instr),
    .rvValid    (rvValid),
    .regWrite   (rvRegWrite),
    .memWrite   (rvMemWrite),
    .memSize    (rvMemSize),
    .memSigned  (rvMemSigned),
    .aluControl (rvAluControl),
    .branch     (rvBranch),
    .aluSrc     (rvAluSrc),
    .immSrc     (rvImmSrc),
    .cond       (rvCond),
    .resultSrc  (rvResultSrc),
    .jump       (rvJump),
    .pcRes      (rvPcRes)
  );

  armDecoder u_armDecoder (
    .instr      (instr),
    .armValid   (armValid),
    .regWrite   (armRegWrite),
    .memWrite   (armMemWrite),
    .memtoReg   (armMemtoReg),
    .aluSrc     (armAluSrc),
    .immSrc     (armImmSrc),
    .regSrc     (armRegSrc),
    .aluControl (armAluControl),
    .branch     (armBranch),
    .flagWrite  (armFlagWrite),
    .pcSrc      (armPcSrc)
  );

  // a word valid in only one ISA selects it, flushed words never do
  always_comb begin
    armNext = armIn;
    illegal = 1'b0;
    if (!flushed) begin
      case ({rvValid, armValid})
        2'b10:   armNext = 1'b0;
        2'b01:   armNext = 1'b1;
        2'b00:   illegal = 1'b1; // mode stays put
        default: armNext = armIn;
      endcase
    end
  end

  assign regWrite   = armNext ? armRegWrite : rvRegWrite;
  assign memWrite   = armNext ? armMemWrite : rvMemWrite;
  assign memSize    = armNext ? decodePkg::MEM_WORD : rvMemSize; // ARM is word only
  assign memSigned  = ~armNext & rvMemSigned;
  assign aluControl = armNext ? {2'b00, armAluControl} : rvAluControl;
  assign branch     = armNext ? {armBranch, 1'b0} : rvBranch;
  assign aluSrc     = armNext ? armAluSrc : rvAluSrc;
  assign immSrc     = armNext ? {1'b0, armImmSrc} : rvImmSrc;
  assign cond       = armNext ? instr[31:28] : rvCond;
  assign resultSrc  = armNext ? {1'b0, armMemtoReg} : rvResultSrc;
  assign jump       = ~armNext & rvJump;
  assign pcRes      = ~armNext & rvPcRes;
  assign pcSrc      = armNext & armPcSrc;
  assign flagWrite  = armNext ? armFlagWrite : 2'b00;
  assign regSrc     = armNext ? armRegSrc : 2'b00;

  // armIn turns known when the mode register in decodeOutReg leaves reset
  always_comb begin
    if (!$isunknown({armIn, flushed, instr})) begin
      assert (!$isunknown(armNext))
        else $error("combiDecoder: ISA mode select is unknown");
    end
  end

endmodule

/* logic/decodeOutReg.sv */
`timescale 1ns/100ps

module decodeOutReg (
  input  logic               clk,
  input  logic               arstN,
  input  logic               instrValid,
  input  decodePkg::instrT   instr,
  input  logic               armNext,
  input  logic               illegal,
  input  logic               decRegWrite,
  input  logic               decMemWrite,
  input  decodePkg::memSizeT decMemSize,
  input  logic               decMemSigned,
  input  decodePkg::aluCtrlT decAluControl,
  input  logic [1:0]         decBranch,
  input  logic               decAluSrc,
  input  decodePkg::immSrcT  decImmSrc,
  input  decodePkg::condT    decCond,
  input  logic               decPcSrc,
  input  logic [1:0]         decFlagWrite,
  input  logic [1:0]         decRegSrc,
  input  logic [1:0]         decResultSrc,
  input  logic               decJump,
  input  logic               decPcRes,
  input  logic               execCreditReturn,
  output logic               armIn,
  output logic               fetchCredit,
  output logic               outValid,
  output decodePkg::instrT   outInstr,
  output logic               armMode,
  output logic               outIllegal,
  output logic               regWrite,
  output logic               memWrite,
  output decodePkg::memSizeT memSize,
  output logic               memSigned,
  output decodePkg::aluCtrlT aluControl,
  output logic [1:0]         branch,
  output logic               aluSrc,
  output decodePkg::immSrcT  immSrc,
  output decodePkg::condT    cond,
  output logic               pcSrc,
  output logic [1:0]         flagWrite,
  output logic [1:0]         regSrc,
  output logic [1:0]         resultSrc,
  output logic               jump,
  output logic               pcRes
);

  logic [decodePkg::BUNDLE_W-1:0]  bundleMem [decodePkg::OUT_DEPTH];
  decodePkg::instrT                instrMem  [decodePkg::OUT_DEPTH];
  logic [decodePkg::OUT_DEPTH-1:0] modeTag, illegalTag;
  logic [decodePkg::BUNDLE_W-1:0]  wrBundle;
  logic [decodePkg::OUT_PTR_W-1:0] wrPtr, rdPtr;
  logic [decodePkg::OUT_PTR_W:0]   count;
  decodePkg::creditT               execCredits;
  logic                            armQ;

  assign wrBundle = {decRegWrite, decMemWrite, decMemSize, decMemSigned, decAluControl,
                     decBranch, decAluSrc, decImmSrc, decCond, decPcSrc, decFlagWrite,
                     decRegSrc, decResultSrc, decJump, decPcRes};

  assign {regWrite, memWrite, memSize, memSigned, aluControl, branch, aluSrc, immSrc,
          cond, pcSrc, flagWrite, regSrc, resultSrc, jump, pcRes} = bundleMem[rdPtr];

  assign outInstr   = instrMem[rdPtr];
  assign armMode    = modeTag[rdPtr];
  assign outIllegal = illegalTag[rdPtr];
  assign armIn      = armQ;

  assign outValid = (count != '0) && (execCredits != '0); // head pops on every output

  always_ff @(posedge clk) begin
    if (instrValid) begin
      bundleMem[wrPtr] <= wrBundle;
      instrMem[wrPtr]  <= instr;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      armQ       <= 1'b0; // RISC-V
      modeTag    <= '0;
      illegalTag <= '0;
      wrPtr      <= '0;
      rdPtr      <= '0;
      count      <= '0;
    end else begin
      if (instrValid) begin
        armQ              <= armNext;
        modeTag[wrPtr]    <= armNext;
        illegalTag[wrPtr] <= illegal;
        wrPtr             <= wrPtr + 1'b1;
      end
      if (outValid) begin
        rdPtr <= rdPtr + 1'b1;
      end
      case ({instrValid, outValid})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      execCredits <= decodePkg::creditT'(decodePkg::EXEC_CREDITS);
      fetchCredit <= 1'b0;
    end else begin
      execCredits <= execCredits - decodePkg::creditT'(outValid)
                                 + decodePkg::creditT'(execCreditReturn);
      fetchCredit <= outValid; // slot freed, hand credit back
    end
  end

  // fetch credits must keep it off a full buffer
  assert property (@(posedge clk) disable iff (!arstN)
    instrValid |-> count < decodePkg::OUT_DEPTH)
    else $error("decodeOutReg: write into full buffer");

  assert property (@(posedge clk) disable iff (!arstN)
    (execCredits == '0 && !execCreditReturn) |=> !outValid)
    else $error("decodeOutReg: output sent without execute credit");

  // execute returns no more than it was given
  assert property (@(posedge clk) disable iff (!arstN)
    execCredits <= decodePkg::creditT'(decodePkg::EXEC_CREDITS))
    else $error("decodeOutReg: execute credit overflow");

endmodule

/* logic/decodeStage.sv */
`timescale 1ns/100ps

module decodeStage (
  input  logic               clk,
  input  logic               arstN,
  input  logic               instrValid,
  input  decodePkg::instrT   instr,
  input  logic               flushed,
  output logic               fetchCredit,
  output logic               outValid,
  output decodePkg::instrT   outInstr,
  output logic               armMode,
  output logic               outIllegal,
  output logic               regWrite,
  output logic               memWrite,
  output decodePkg::memSizeT memSize,
  output logic               memSigned,
  output decodePkg::aluCtrlT aluControl,
  output logic [1:0]         branch,
  output logic               aluSrc,
  output decodePkg::immSrcT  immSrc,
  output decodePkg::condT    cond,
  output logic               pcSrc,
  output logic [1:0]         flagWrite,
  output logic [1:0]         regSrc,
  output logic [1:0]         resultSrc,
  output logic               jump,
  output logic               pcRes,
  input  logic               execCreditReturn
);

  logic               armIn, armNext, illegal;
  logic               decRegWrite, decMemWrite, decMemSigned, decAluSrc;
  logic               decPcSrc, decJump, decPcRes;
  decodePkg::memSizeT decMemSize;
  decodePkg::aluCtrlT decAluControl;
  decodePkg::immSrcT  decImmSrc;
  decodePkg::condT    decCond;
  logic [1:0]         decBranch, decFlagWrite, decRegSrc, decResultSrc;

  combiDecoder u_combiDecoder (
    .instr      (instr),
    .flushed    (flushed),
    .armIn      (armIn),
    .armNext    (armNext),
    .illegal    (illegal),
    .regWrite   (decRegWrite),
    .memWrite   (decMemWrite),
    .memSize    (decMemSize),
    .memSigned  (decMemSigned),
    .aluControl (decAluControl),
    .branch     (decBranch),
    .aluSrc     (decAluSrc),
    .immSrc     (decImmSrc),
    .cond       (decCond),
    .pcSrc      (decPcSrc),
    .flagWrite  (decFlagWrite),
    .regSrc     (decRegSrc),
    .resultSrc  (decResultSrc),
    .jump       (decJump),
    .pcRes      (decPcRes)
  );

  decodeOutReg u_decodeOutReg (
    .clk              (clk),
    .arstN            (arstN),
    .instrValid       (instrValid),
    .instr            (instr),
    .armNext          (armNext),
    .illegal          (illegal),
    .decRegWrite      (decRegWrite),
    .decMemWrite      (decMemWrite),
    .decMemSize       (decMemSize),
    .decMemSigned     (decMemSigned),
    .decAluControl    (decAluControl),
    .decBranch        (decBranch),
    .decAluSrc        (decAluSrc),
    .decImmSrc        (decImmSrc),
    .decCond          (decCond),
    .decPcSrc         (decPcSrc),
    .decFlagWrite     (decFlagWrite),
    .decRegSrc        (decRegSrc),
    .decResultSrc     (decResultSrc),
    .decJump          (decJump),
    .decPcRes         (decPcRes),
    .execCreditReturn (execCreditReturn),
    .armIn            (armIn),
    .fetchCredit      (fetchCredit),
    .outValid         (outValid),
    .outInstr         (outInstr),
    .armMode          (armMode),
    .outIllegal       (outIllegal),
    .regWrite         (regWrite),
    .memWrite         (memWrite),
    .memSize          (memSize),
    .memSigned        (memSigned),
    .aluControl       (aluControl),
    .branch           (branch),
    .aluSrc           (aluSrc),
    .immSrc           (immSrc),
    .cond             (cond),
    .pcSrc            (pcSrc),
    .flagWrite        (flagWrite),
    .regSrc           (regSrc),
    .resultSrc        (resultSrc),
    .jump             (jump),
    .pcRes            (pcRes)
  );

endmodule

/* verif/decodeStageTb.sv */
`timescale 1ns/100ps

module decodeStageTb;

  localparam int FIELDS    = 12; // values per stimulus line
  localparam int MAX_LINES = 64;

  logic               clk, arstN, instrValid, flushed, execCreditReturn;
  decodePkg::instrT   instr;
  logic               fetchCredit, outValid, armMode, outIllegal;
  decodePkg::instrT   outInstr;
  logic               regWrite, memWrite, memSigned, aluSrc, pcSrc, jump, pcRes;
  decodePkg::memSizeT memSize;
  decodePkg::aluCtrlT aluControl;
  decodePkg::immSrcT  immSrc;
  decodePkg::condT    cond;
  logic [1:0]         branch, flagWrite, regSrc, resultSrc;

  logic [31:0] stimMem [FIELDS*MAX_LINES];
  int          numLines, holdSum, sendIdx, outIdx, fetchCreds, execBusy;
  int          holdLeft, holdLen, holdLine, holdBudget, holdOut, holdFc;
  int          errCount, testsRun, testFails, cycleCount, cycleLimit;
  integer      seed;
  bit          limitReady;

  decodeStage u_decodeStage (
    .clk(clk), .arstN(arstN), .instrValid(instrValid), .instr(instr), .flushed(flushed),
    .fetchCredit(fetchCredit), .outValid(outValid), .outInstr(outInstr), .armMode(armMode),
    .outIllegal(outIllegal), .regWrite(regWrite), .memWrite(memWrite), .memSize(memSize),
    .memSigned(memSigned), .aluControl(aluControl), .branch(branch), .aluSrc(aluSrc),
    .immSrc(immSrc), .cond(cond), .pcSrc(pcSrc), .flagWrite(flagWrite), .regSrc(regSrc),
    .resultSrc(resultSrc), .jump(jump), .pcRes(pcRes), .execCreditReturn(execCreditReturn)
  );

  always begin
    clk = 1'b0;
    #20;
    clk = 1'b1;
    #20;
  end

  task automatic checkAlu(input string name, input decodePkg::aluCtrlT expVal,
                          input decodePkg::aluCtrlT actVal);
    if (actVal !== expVal) begin
      $display("MISMATCH t=%0t %s expected %h got %h", $time, name, expVal, actVal);
      errCount++;
    end
  endtask

  task automatic checkCond(input string name, input decodePkg::condT expVal,
                           input decodePkg::condT actVal);
    if (actVal !== expVal) begin
      $display("MISMATCH t=%0t %s expected %h got %h", $time, name, expVal, actVal);
      errCount++;
    end
  endtask

  task automatic checkInstr(input string name, input decodePkg::instrT expVal,
                            input decodePkg::instrT actVal);
    if (actVal !== expVal) begin
      $display("MISMATCH t=%0t %s expected %h got %h", $time, name, expVal, actVal);
      errCount++;
    end
  endtask

  task automatic checkPair(input string name, input logic [1:0] expVal,
                           input logic [1:0] actVal);
    if (actVal !== expVal) begin
      $display("MISMATCH t=%0t %s expected %b got %b", $time, name, expVal, actVal);
      errCount++;
    end
  endtask

  task automatic checkBit(input string name, input logic expVal, input logic actVal);
    if (actVal !== expVal) begin
      $display("MISMATCH t=%0t %s expected %b got %b", $time, name, expVal, actVal);
      errCount++;
    end
  endtask

  task automatic checkMode(input logic expVal, input logic actVal);
    if (actVal !== expVal) begin
      $display("MISMATCH t=%0t armMode expected %s got %s", $time,
               expVal ? "ARM" : "RISC-V", (actVal === 1'b1) ? "ARM" : "RISC-V/unknown");
      errCount++;
    end
  endtask

  task automatic countLines();
    bit found;
    found    = 1'b0;
    numLines = 0;
    holdSum  = 0;
    for (int n = 0; n < MAX_LINES && !found; n++) begin
      if (stimMem[n*FIELDS+1] == 32'hF) begin
        found = 1'b1; // end marker
      end else begin
        numLines++;
        holdSum += int'(stimMem[n*FIELDS+2]);
      end
    end
    if (!found || numLines == 0) begin
      $display("stimulus file is missing, empty or has no end marker");
      errCount++;
      numLines = 0;
    end
  endtask

  task automatic checkReset(input string phase);
    int errBefore;
    errBefore = errCount;
    checkBit("outValid", 1'b0, outValid);
    checkBit("fetchCredit", 1'b0, fetchCredit);
    checkMode(1'b0, armMode);
    testsRun++;
    if (errCount == errBefore) begin
      $display("reset test %s ok", phase);
    end else begin
      $display("reset test %s failed", phase);
      testFails++;
    end
  endtask

  // compares the head expected line with the bundle at the outputs
  task automatic checkOutput();
    int base, errBefore;
    base      = outIdx * FIELDS;
    errBefore = errCount;
    checkInstr("outInstr", stimMem[base], outInstr);
    checkMode(stimMem[base+3][0], armMode);
    checkBit("outIllegal", stimMem[base+4][0], outIllegal);
    checkAlu("aluControl", stimMem[base+5][3:0], aluControl);
    checkCond("cond", stimMem[base+6][3:0], cond);
    checkBit("regWrite", stimMem[base+7][0], regWrite);
    checkBit("memWrite", stimMem[base+8][0], memWrite);
    checkPair("branch", stimMem[base+9][1:0], branch);
    checkPair("flagWrite", stimMem[base+10][1:0], flagWrite);
    checkBit("pcSrc", stimMem[base+11][0], pcSrc);
    if (stimMem[base+3][0]) begin // ARM is word sized, unsigned, no RISC-V only fields
      checkPair("memSize", 2'b10, memSize);
      checkBit("memSigned", 1'b0, memSigned);
      checkBit("jump", 1'b0, jump);
      checkBit("pcRes", 1'b0, pcRes);
      checkBit("immSrc[2]", 1'b0, immSrc[2]);
      checkBit("resultSrc[1]", 1'b0, resultSrc[1]);
    end else begin
      checkPair("regSrc", 2'b00, regSrc);
    end
    testsRun++;
    if (errCount == errBefore) begin
      $display("test %0d instr %h ok", outIdx, stimMem[base]);
    end else begin
      $display("test %0d instr %h failed", outIdx, stimMem[base]);
      testFails++;
    end
    outIdx++;
  endtask

  task automatic reportHold();
    testsRun++;
    if (holdOut > holdBudget || holdFc > holdBudget + 1) begin
      $display("back-pressure test after line %0d failed: %0d outputs and %0d fetch credits %s",
               holdLine, holdOut, holdFc, "came while execute had no room for them");
      errCount++;
      testFails++;
    end else begin
      $display("back-pressure test after line %0d ok, %0d outputs in a %0d-cycle hold",
               holdLine, holdOut, holdLen);
    end
  endtask

  // one falling edge: sample outputs, then model execute and fetch
  task automatic stepCycle();
    int base, prevBusy, rnd;
    prevBusy = execBusy;
    if (outValid === 1'b1) begin
      if (execBusy >= decodePkg::EXEC_CREDITS) begin
        $display("output at t=%0t overruns the execute queue", $time);
        errCount++;
      end
      if (outIdx >= numLines) begin
        $display("unexpected output %h at t=%0t after the last instruction", outInstr, $time);
        errCount++;
      end else begin
        checkOutput();
      end
      execBusy++;
      if (holdLeft > 0) holdOut++;
    end
    if (fetchCredit === 1'b1) begin
      fetchCreds++;
      if (holdLeft > 0) holdFc++;
      if (fetchCreds > decodePkg::OUT_DEPTH) begin
        $display("fetch credit at t=%0t exceeds the buffer depth", $time);
        errCount++;
      end
    end
    if (holdLeft > 0) begin
      holdLeft--;
      if (holdLeft == 0) reportHold();
    end
    rnd              = $random(seed);
    execCreditReturn = (holdLeft == 0) && (prevBusy > 0) && rnd[0];
    if (execCreditReturn) execBusy--;
    if (sendIdx < numLines && fetchCreds > 0) begin
      base       = sendIdx * FIELDS;
      instrValid = 1'b1;
      instr      = stimMem[base];
      flushed    = stimMem[base+1][0];
      fetchCreds--;
      if (stimMem[base+2] != 0) begin
        holdLen    = int'(stimMem[base+2]);
        holdLeft   = holdLen;
        holdLine   = sendIdx;
        holdBudget = decodePkg::EXEC_CREDITS - execBusy; // room left in execute
        holdOut    = 0;
        holdFc     = 0;
      end
      sendIdx++;
    end else begin
      instrValid = 1'b0;
      flushed    = 1'b0;
    end
  endtask

  initial begin : stimulus
    arstN            = 1'b0;
    instrValid       = 1'b0;
    instr            = '0;
    flushed          = 1'b0;
    execCreditReturn = 1'b0;
    seed             = 32'h5a0b;
    fetchCreds       = decodePkg::OUT_DEPTH;
    $readmemh("verif/decodeStim.txt", stimMem);
    countLines();
    cycleLimit = 4 * numLines + holdSum + 200;
    limitReady = 1'b1;
    repeat (10) @(posedge clk);
    @(negedge clk);
    checkReset("in reset");
    arstN = 1'b1;
    @(negedge clk);
    checkReset("after release");
    while (outIdx < numLines) begin
      @(negedge clk);
      stepCycle();
    end
    repeat (3) begin // last fetch credit still in flight
      @(negedge clk);
      stepCycle();
    end
    if (fetchCreds != decodePkg::OUT_DEPTH) begin
      $display("fetch holds %0d credits at the end instead of %0d", fetchCreds,
               decodePkg::OUT_DEPTH);
      errCount++;
    end
    $display("%0d tests run, %0d failed, %0d errors", testsRun, testFails, errCount);
    if (errCount == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    wait (limitReady);
    cycleCount = 0;
    while (cycleCount < cycleLimit) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("timeout after %0d cycles with %0d of %0d instructions received",
             cycleCount, outIdx, numLines);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

/* combiDecode.f */
logic/decodePkg.sv
logic/rvDecoder.sv
logic/armDecoder.sv
logic/combiDecoder.sv
logic/decodeOutReg.sv
logic/decodeStage.sv
verif/decodeStageTb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = decodeStageTb
FILELIST = combiDecode.f
OBJ      = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ) -f $(FILELIST)

# the run passes only when the log holds the pass line
run: compile
	./$(OBJ)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "ALL TESTS PASSED" $(LOG); then \
		echo "simulation result: pass"; \
	else \
		echo "simulation result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ) $(LOG)

/* verif/decodeStim.txt */
// decode stage stimulus, one instruction per line, all fields hex
// instr flushed hold mode illegal aluControl cond regWrite memWrite branch flagWrite pcSrc
// a line with flushed = F ends the list
002081B3 0 0  0 0 0 E 1 0 0 0 0 // add
40208233 0 0  0 0 1 E 1 0 0 0 0 // sub
4020D2B3 0 0  0 0 A E 1 0 0 0 0 // sra
0020A333 0 0  0 0 5 E 1 0 0 0 0 // slt
00408383 0 1E 0 0 0 E 1 0 0 0 0 // lb, also an ARM SUB, mode kept
0020A423 0 0  0 0 0 E 0 1 0 0 0 // sw
00208463 0 0  0 0 1 0 0 0 1 0 0 // beq
0020C463 0 0  0 0 1 B 0 0 1 0 0 // blt
010000EF 0 0  0 0 0 E 1 0 1 0 0 // jal
E0921004 0 0  1 0 0 E 1 0 0 3 0 // ADDS r1,r2,r4 switches to ARM
E2465001 0 0  1 0 1 E 1 0 0 0 0 // SUB r5,r6,#1
E1932004 0 0  1 0 3 E 1 0 0 2 0 // ORRS, logical so no C/V write
10021004 0 0  1 0 2 1 1 0 0 0 0 // ANDNE
E5921004 0 0  1 0 0 E 1 0 0 0 0 // LDR
E5821008 0 19 1 0 0 E 0 1 0 0 0 // STR
EA000004 0 0  1 0 0 E 0 0 2 0 0 // B
E081F004 0 0  1 0 0 E 1 0 0 0 1 // ADD pc,r1,r4
00408383 0 0  1 0 1 0 1 0 0 0 0 // valid in both, stays ARM
FFFFFFFF 0 0  1 1 0 F 0 0 0 0 0 // valid in neither
002081B3 1 0  1 0 0 0 1 0 0 0 0 // flushed RISC-V word
FFFFFFFF 1 0  1 0 0 F 0 0 0 0 0 // flushed, never illegal
002081B3 0 0  0 0 0 E 1 0 0 0 0 // add back to RISC-V
FFFFFFFF 0 0  0 1 0 E 0 0 0 0 0 // valid in neither
E0921004 1 0  0 0 0 E 0 0 0 0 0 // flushed ARM word
00000000 F 0  0 0 0 0 0 0 0 0 0
